// File: design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN       32
`define CORE_REG_COUNT  32
`define CORE_REG_IDX_W  5
`define CORE_RESET_PC   32'h0000_0000

// RV32I major opcodes
`define CORE_OPC_OP     7'b0110011
`define CORE_OPC_OPIMM  7'b0010011
`define CORE_OPC_LUI    7'b0110111

`define CORE_F3_ADD     3'b000
`define CORE_F3_SLL     3'b001
`define CORE_F3_SLT     3'b010
`define CORE_F3_SLTU    3'b011
`define CORE_F3_XOR     3'b100
`define CORE_F3_SR      3'b101
`define CORE_F3_OR      3'b110
`define CORE_F3_AND     3'b111

`define CORE_F7_BASE    7'b0000000
`define CORE_F7_ALT     7'b0100000

`endif

// File: design/corePkg.sv
`default_nettype none

`include "core_config.svh"

package corePkg;

    typedef logic [`CORE_XLEN-1:0] wordT;
    typedef logic [`CORE_REG_IDX_W-1:0] regIdxT;

    // PassB carries the LUI immediate straight through
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOpT;

    typedef struct packed {
        wordT   pc;
        aluOpT  aluOp;
        regIdxT rd;
        logic   wen;
        wordT   opA;
        wordT   opB;
    } issueT;

endpackage

`default_nettype wire

// File: design/coreIfs.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch buffer to decode, valid/ready handshake
interface fetchIf;
    logic          valid;
    logic          ready;
    corePkg::wordT instr;
    corePkg::wordT pc;

    modport source (output valid, output instr, output pc, input ready);
    modport sink (input valid, input instr, input pc, output ready);
endinterface

// Combinational register read, no write bypass
interface regReadIf;
    corePkg::regIdxT rs1;
    corePkg::regIdxT rs2;
    corePkg::wordT   data1;
    corePkg::wordT   data2;

    modport requester (output rs1, output rs2, input data1, input data2);
    modport responder (input rs1, input rs2, output data1, output data2);
endinterface

// One strobe per retired instruction
interface retireIf;
    logic            valid;
    corePkg::wordT   pc;
    corePkg::regIdxT rd;
    logic            wen;
    corePkg::wordT   data;

    modport source (output valid, output pc, output rd, output wen, output data);
    modport sink (input valid, input pc, input rd, input wen, input data);
endinterface

`default_nettype wire

// File: design/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module fetchUnit (
    input  logic          clk,
    input  logic          arstN,
    output corePkg::wordT axiAraddr,
    output logic          axiArvalid,
    input  logic          axiArready,
    input  corePkg::wordT axiRdata,
    input  logic          axiRvalid,
    output logic          axiRready,
    fetchIf.source        fetch
);

    typedef enum logic [1:0] {
        stIdle,
        stAddr,
        stData,
        stHold
    } stateT;

    stateT         state;
    corePkg::wordT pc;
    corePkg::wordT instrBuf;

    // Single read in flight, buffer drains before the next address
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
            pc    <= `CORE_RESET_PC;
        end else begin
            case (state)
                stIdle: state <= stAddr;
                stAddr: if (axiArready) state <= stData;
                stData: if (axiRvalid) state <= stHold;
                stHold: begin
                    if (fetch.ready) begin
                        state <= stAddr;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stData && axiRvalid) begin
            instrBuf <= axiRdata;
        end
    end

    assign axiAraddr  = pc;
    assign axiArvalid = (state == stAddr);
    assign axiRready  = (state == stData);

    // PC stays put while the word waits in the buffer
    assign fetch.valid = (state == stHold);
    assign fetch.instr = instrBuf;
    assign fetch.pc    = pc;

endmodule

`default_nettype wire

// File: design/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module decodeStage (
    input  logic           clk,
    input  logic           arstN,
    fetchIf.sink           fetch,
    regReadIf.requester    regRead,
    retireIf.sink          retire,
    output logic           issueValid,
    output corePkg::issueT issue
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    corePkg::regIdxT rd;
    corePkg::regIdxT rs1;
    corePkg::regIdxT rs2;
    corePkg::wordT   immI;
    corePkg::wordT   immU;
    logic            isOp;
    logic            isOpImm;
    logic            isLui;
    logic            known;
    corePkg::aluOpT  aluOp;
    logic            hazard;
    corePkg::issueT  nextIssue;

    assign opcode = fetch.instr[6:0];
    assign rd     = fetch.instr[11:7];
    assign funct3 = fetch.instr[14:12];
    assign rs1    = fetch.instr[19:15];
    assign rs2    = fetch.instr[24:20];
    assign funct7 = fetch.instr[31:25];

    assign immI = {{(`CORE_XLEN-12){fetch.instr[31]}}, fetch.instr[31:20]};
    assign immU = {fetch.instr[31:12], 12'b0};

    assign isOp    = (opcode == `CORE_OPC_OP);
    assign isOpImm = (opcode == `CORE_OPC_OPIMM);
    assign isLui   = (opcode == `CORE_OPC_LUI);

    always_comb begin
        aluOp = corePkg::aluAdd;
        known = 1'b0;
        if (isOp) begin
            // Only ADD/SUB and SRL/SRA accept the alternate funct7
            known = (funct7 == `CORE_F7_BASE) ||
                    ((funct7 == `CORE_F7_ALT) &&
                     (funct3 == `CORE_F3_ADD || funct3 == `CORE_F3_SR));
            case (funct3)
                `CORE_F3_ADD:  aluOp = (funct7 == `CORE_F7_ALT) ? corePkg::aluSub
                                                                : corePkg::aluAdd;
                `CORE_F3_SLL:  aluOp = corePkg::aluSll;
                `CORE_F3_SLT:  aluOp = corePkg::aluSlt;
                `CORE_F3_SLTU: aluOp = corePkg::aluSltu;
                `CORE_F3_XOR:  aluOp = corePkg::aluXor;
                `CORE_F3_SR:   aluOp = (funct7 == `CORE_F7_ALT) ? corePkg::aluSra
                                                                : corePkg::aluSrl;
                `CORE_F3_OR:   aluOp = corePkg::aluOr;
                default:       aluOp = corePkg::aluAnd;
            endcase
        end else if (isOpImm) begin
            known = 1'b1;
            case (funct3)
                `CORE_F3_ADD:  aluOp = corePkg::aluAdd;
                `CORE_F3_SLL: begin
                    aluOp = corePkg::aluSll;
                    known = (funct7 == `CORE_F7_BASE);
                end
                `CORE_F3_SLT:  aluOp = corePkg::aluSlt;
                `CORE_F3_SLTU: aluOp = corePkg::aluSltu;
                `CORE_F3_XOR:  aluOp = corePkg::aluXor;
                `CORE_F3_SR: begin
                    aluOp = (funct7 == `CORE_F7_ALT) ? corePkg::aluSra : corePkg::aluSrl;
                    known = (funct7 == `CORE_F7_BASE) || (funct7 == `CORE_F7_ALT);
                end
                `CORE_F3_OR:   aluOp = corePkg::aluOr;
                default:       aluOp = corePkg::aluAnd;
            endcase
        end else if (isLui) begin
            known = 1'b1;
            aluOp = corePkg::aluPassB;
        end
    end

    // Source still owed by the issue register or the retire strobe
    function automatic logic pending(input corePkg::regIdxT src);
        return (src != '0) &&
               ((issueValid && issue.wen && issue.rd == src) ||
                (retire.valid && retire.wen && retire.rd == src));
    endfunction

    assign hazard = ((isOp || isOpImm) && pending(rs1)) || (isOp && pending(rs2));

    assign fetch.ready = !hazard;
    assign regRead.rs1 = rs1;
    assign regRead.rs2 = rs2;

    always_comb begin
        nextIssue.pc    = fetch.pc;
        nextIssue.aluOp = aluOp;
        nextIssue.rd    = rd;
        nextIssue.wen   = known && (rd != '0);
        nextIssue.opA   = isLui ? '0 : regRead.data1;
        if (isOp) begin
            nextIssue.opB = regRead.data2;
        end else if (isLui) begin
            nextIssue.opB = immU;
        end else begin
            nextIssue.opB = immI;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= fetch.valid && fetch.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.valid && fetch.ready) begin
            issue <= nextIssue;
        end
    end

endmodule

`default_nettype wire

// File: design/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module executeStage (
    input  logic           clk,
    input  logic           arstN,
    input  logic           issueValid,
    input  corePkg::issueT issue,
    retireIf.source        retire
);

    logic [4:0]    shamt;
    corePkg::wordT result;

    assign shamt = issue.opB[4:0];

    always_comb begin
        case (issue.aluOp)
            corePkg::aluAdd:   result = issue.opA + issue.opB;
            corePkg::aluSub:   result = issue.opA - issue.opB;
            corePkg::aluSll:   result = issue.opA << shamt;
            corePkg::aluSlt:   result = {{(`CORE_XLEN-1){1'b0}},
                                         $signed(issue.opA) < $signed(issue.opB)};
            corePkg::aluSltu:  result = {{(`CORE_XLEN-1){1'b0}}, issue.opA < issue.opB};
            corePkg::aluXor:   result = issue.opA ^ issue.opB;
            corePkg::aluSrl:   result = issue.opA >> shamt;
            corePkg::aluSra:   result = $signed(issue.opA) >>> shamt;
            corePkg::aluOr:    result = issue.opA | issue.opB;
            corePkg::aluAnd:   result = issue.opA & issue.opB;
            corePkg::aluPassB: result = issue.opB;
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) begin
            retire.pc   <= issue.pc;
            retire.rd   <= issue.rd;
            retire.wen  <= issue.wen;
            retire.data <= result;
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module regFile (
    input  logic          clk,
    input  logic          arstN,
    regReadIf.responder   regRead,
    retireIf.sink         retire
);

    // x0 has no storage
    corePkg::wordT regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.wen && retire.rd != '0) begin
            regs[retire.rd] <= retire.data;
        end
    end

    assign regRead.data1 = (regRead.rs1 == '0) ? '0 : regs[regRead.rs1];
    assign regRead.data2 = (regRead.rs2 == '0) ? '0 : regs[regRead.rs2];

endmodule

`default_nettype wire

// File: design/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic            clk,
    input  logic            arstN,
    output corePkg::wordT   axiAraddr,
    output logic            axiArvalid,
    input  logic            axiArready,
    input  corePkg::wordT   axiRdata,
    input  logic            axiRvalid,
    output logic            axiRready,
    output logic            retireValid,
    output corePkg::wordT   retirePc,
    output corePkg::regIdxT retireRd,
    output logic            retireWen,
    output corePkg::wordT   retireData
);

    fetchIf   fetchBus ();
    regReadIf regReadBus ();
    retireIf  retireBus ();

    logic           issueValid;
    corePkg::issueT issue;

    fetchUnit fetchUnit_i (
        .clk        (clk),
        .arstN      (arstN),
        .axiAraddr  (axiAraddr),
        .axiArvalid (axiArvalid),
        .axiArready (axiArready),
        .axiRdata   (axiRdata),
        .axiRvalid  (axiRvalid),
        .axiRready  (axiRready),
        .fetch      (fetchBus.source)
    );

    decodeStage decodeStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .fetch      (fetchBus.sink),
        .regRead    (regReadBus.requester),
        .retire     (retireBus.sink),
        .issueValid (issueValid),
        .issue      (issue)
    );

    executeStage executeStage_i (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .issue      (issue),
        .retire     (retireBus.source)
    );

    regFile regFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .regRead (regReadBus.responder),
        .retire  (retireBus.sink)
    );

    // Retire trace
    assign retireValid = retireBus.valid;
    assign retirePc    = retireBus.pc;
    assign retireRd    = retireBus.rd;
    assign retireWen   = retireBus.wen;
    assign retireData  = retireBus.data;

endmodule

`default_nettype wire

// File: testbench/retireChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module retireChecker (
    input  logic            clk,
    input  logic            arstN,
    input  corePkg::wordT   axiAraddr,
    input  logic            axiArvalid,
    input  logic            axiArready,
    input  corePkg::wordT   axiRdata,
    input  logic            axiRvalid,
    input  logic            axiRready,
    input  logic            retireValid,
    input  corePkg::wordT   retirePc,
    input  corePkg::regIdxT retireRd,
    input  logic            retireWen,
    input  corePkg::wordT   retireData,
    output int              retired,
    output int              retireErrors,
    output int              protocolErrors
);

    logic [31:0] addrQ [$];
    logic [31:0] fetchPcQ [$];
    logic [31:0] fetchWordQ [$];
    logic [31:0] model [0:31];
    logic [31:0] expFetchPc;
    logic [31:0] expRetirePc;
    logic [31:0] prevAraddr;
    logic        prevArvalid;
    logic        prevArready;
    logic        afterReset;
    int          retiredCnt = 0;
    int          retErrCnt = 0;
    int          protErrCnt = 0;

    task automatic mismatch(input string name, input logic [31:0] expected,
                            input logic [31:0] actual, input logic onRetire);
        $display("Error %s: expected %h, got %h", name, expected, actual);
        if (onRetire) begin
            retErrCnt++;
        end else begin
            protErrCnt++;
        end
    endtask

    task automatic checkQuiet();
        if (axiArvalid !== 1'b0) begin
            mismatch("axiArvalid", 32'h0, {31'h0, axiArvalid}, 1'b0);
        end
        if (axiRready !== 1'b0) begin
            mismatch("axiRready", 32'h0, {31'h0, axiRready}, 1'b0);
        end
        if (retireValid !== 1'b0) begin
            mismatch("retireValid", 32'h0, {31'h0, retireValid}, 1'b0);
        end
    endtask

    // Reference result of one instruction word on the model registers
    task automatic modelExec(input logic [31:0] word, output logic wen,
                             output logic [31:0] value);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic        ok;
        opc = word[6:0];
        f7 = word[31:25];
        a = model[word[19:15]];
        b = (opc == `CORE_OPC_OP) ? model[word[24:20]] : {{20{word[31]}}, word[31:20]};
        ok = (opc == `CORE_OPC_OPIMM) || (f7 == `CORE_F7_BASE);
        value = '0;
        case (word[14:12])
            `CORE_F3_ADD: begin
                ok = ok || (f7 == `CORE_F7_ALT);
                value = (opc == `CORE_OPC_OP && f7 == `CORE_F7_ALT) ? a - b : a + b;
            end
            `CORE_F3_SLL: begin
                ok = (f7 == `CORE_F7_BASE);
                value = a << b[4:0];
            end
            `CORE_F3_SLT:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `CORE_F3_SLTU: value = (a < b) ? 32'd1 : 32'd0;
            `CORE_F3_XOR:  value = a ^ b;
            `CORE_F3_SR: begin
                ok = (f7 == `CORE_F7_BASE) || (f7 == `CORE_F7_ALT);
                if (f7 == `CORE_F7_ALT) begin
                    value = $signed(a) >>> b[4:0];
                end else begin
                    value = a >> b[4:0];
                end
            end
            `CORE_F3_OR:   value = a | b;
            default:       value = a & b;
        endcase
        if (opc == `CORE_OPC_LUI) begin
            ok = 1'b1;
            value = {word[31:12], 12'h000};
        end else if (opc != `CORE_OPC_OP && opc != `CORE_OPC_OPIMM) begin
            ok = 1'b0;
        end
        wen = ok && (word[11:7] != 5'd0);
    endtask

    always @(posedge clk) begin
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] value;
        logic        wen;
        if (!arstN) begin
            checkQuiet();
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
            addrQ.delete();
            fetchPcQ.delete();
            fetchWordQ.delete();
            expFetchPc = `CORE_RESET_PC;
            expRetirePc = `CORE_RESET_PC;
            prevArvalid = 1'b0;
            prevArready = 1'b0;
            prevAraddr = '0;
            afterReset = 1'b0;
        end else begin
            if (!afterReset) begin
                checkQuiet();
                afterReset = 1'b1;
            end
            if (prevArvalid && !prevArready && (!axiArvalid || axiAraddr !== prevAraddr)) begin
                protErrCnt++;
                $display("Read address dropped or changed before axiArready at %h", prevAraddr);
            end
            prevArvalid = axiArvalid;
            prevArready = axiArready;
            prevAraddr = axiAraddr;
            if (axiArvalid && axiArready) begin
                if (axiAraddr !== expFetchPc) begin
                    mismatch("axiAraddr", expFetchPc, axiAraddr, 1'b0);
                end
                addrQ.push_back(axiAraddr);
                expFetchPc = expFetchPc + 32'd4;
            end
            if (axiRvalid && axiRready) begin
                if (addrQ.size() == 0) begin
                    protErrCnt++;
                    $display("Read data accepted with no address outstanding");
                end else begin
                    fetchPcQ.push_back(addrQ.pop_front());
                    fetchWordQ.push_back(axiRdata);
                end
            end
            if (retireValid) begin
                retiredCnt++;
                if (retirePc !== expRetirePc) begin
                    mismatch("retirePc", expRetirePc, retirePc, 1'b1);
                end
                expRetirePc = expRetirePc + 32'd4;
                if (fetchPcQ.size() == 0) begin
                    retErrCnt++;
                    $display("Instruction retired with no fetched word outstanding");
                end else begin
                    pc = fetchPcQ.pop_front();
                    word = fetchWordQ.pop_front();
                    if (retirePc !== pc) begin
                        mismatch("retirePc", pc, retirePc, 1'b1);
                    end
                    modelExec(word, wen, value);
                    if (retireWen !== wen) begin
                        mismatch("retireWen", {31'h0, wen}, {31'h0, retireWen}, 1'b1);
                    end else if (wen) begin
                        if (retireRd !== word[11:7]) begin
                            mismatch("retireRd", {27'h0, word[11:7]}, {27'h0, retireRd}, 1'b1);
                        end
                        if (retireData !== value) begin
                            mismatch("retireData", value, retireData, 1'b1);
                        end
                    end
                    if (wen) begin
                        model[word[11:7]] = value;
                    end
                end
            end
        end
        retired        <= retiredCnt;
        retireErrors   <= retErrCnt;
        protocolErrors <= protErrCnt;
    end

endmodule

`default_nettype wire

// File: testbench/tbCpuCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module tbCpuCore;

    logic            clk;
    logic            arstN;
    corePkg::wordT   axiAraddr;
    logic            axiArvalid;
    logic            axiArready = 1'b0;
    corePkg::wordT   axiRdata = '0;
    logic            axiRvalid = 1'b0;
    logic            axiRready;
    logic            retireValid;
    corePkg::wordT   retirePc;
    corePkg::regIdxT retireRd;
    logic            retireWen;
    corePkg::wordT   retireData;

    int              retired;
    int              retireErrors;
    int              protocolErrors;

    logic [31:0]     mem [0:255];
    logic [31:0]     lfsr;

    cpuCore cpuCore_i (
        .clk         (clk),
        .arstN       (arstN),
        .axiAraddr   (axiAraddr),
        .axiArvalid  (axiArvalid),
        .axiArready  (axiArready),
        .axiRdata    (axiRdata),
        .axiRvalid   (axiRvalid),
        .axiRready   (axiRready),
        .retireValid (retireValid),
        .retirePc    (retirePc),
        .retireRd    (retireRd),
        .retireWen   (retireWen),
        .retireData  (retireData)
    );

    retireChecker retireChecker_i (
        .clk            (clk),
        .arstN          (arstN),
        .axiAraddr      (axiAraddr),
        .axiArvalid     (axiArvalid),
        .axiArready     (axiArready),
        .axiRdata       (axiRdata),
        .axiRvalid      (axiRvalid),
        .axiRready      (axiRready),
        .retireValid    (retireValid),
        .retirePc       (retirePc),
        .retireRd       (retireRd),
        .retireWen      (retireWen),
        .retireData     (retireData),
        .retired        (retired),
        .retireErrors   (retireErrors),
        .protocolErrors (protocolErrors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit, msb first
    task automatic drawBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = galoisStep(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic makeInstr(output logic [31:0] word);
        logic [31:0] pick;
        logic [31:0] f3;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] alt;
        logic [6:0]  f7;
        drawBits(7, pick);
        pick = (pick * 100) >> 7;
        drawBits(3, f3);
        drawBits(3, rd);
        drawBits(3, rs1);
        drawBits(3, rs2);
        drawBits(1, alt);
        f7 = `CORE_F7_BASE;
        if (pick < 45) begin
            if (f3[2:0] == `CORE_F3_ADD || f3[2:0] == `CORE_F3_SR) begin
                f7 = alt[0] ? `CORE_F7_ALT : `CORE_F7_BASE;
            end
            word = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `CORE_OPC_OP};
        end else if (pick < 80) begin
            drawBits(12, imm);
            // Shift immediates carry funct7 in their upper bits
            if (f3[2:0] == `CORE_F3_SLL) begin
                imm[11:5] = `CORE_F7_BASE;
            end else if (f3[2:0] == `CORE_F3_SR) begin
                imm[11:5] = alt[0] ? `CORE_F7_ALT : `CORE_F7_BASE;
            end
            word = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `CORE_OPC_OPIMM};
        end else if (pick < 90) begin
            drawBits(20, imm);
            word = {imm[19:0], rd[4:0], `CORE_OPC_LUI};
        end else begin
            drawBits(32, word);
        end
    endtask

    // Instruction memory and AXI read responder
    initial begin
        logic [31:0] delay;
        logic [31:0] rdAddr;
        logic        dataPhase;
        lfsr = 32'ha421c18d;
        for (int i = 0; i < 256; i++) begin
            makeInstr(mem[i]);
        end
        delay = '0;
        rdAddr = '0;
        dataPhase = 1'b0;
        forever begin
            @(posedge clk);
            if (!arstN) begin
                axiArready <= 1'b0;
                axiRvalid  <= 1'b0;
                dataPhase = 1'b0;
                drawBits(2, delay);
            end else if (!dataPhase) begin
                if (axiArready) begin
                    axiArready <= 1'b0;
                    rdAddr = axiAraddr;
                    dataPhase = 1'b1;
                    drawBits(2, delay);
                end else if (axiArvalid) begin
                    if (delay == 0) begin
                        axiArready <= 1'b1;
                    end else begin
                        delay = delay - 1;
                    end
                end
            end else begin
                if (axiRvalid && axiRready) begin
                    axiRvalid <= 1'b0;
                    dataPhase = 1'b0;
                    drawBits(2, delay);
                end else if (!axiRvalid) begin
                    if (delay == 0) begin
                        axiRvalid <= 1'b1;
                        axiRdata  <= mem[rdAddr[9:2]];
                    end else begin
                        delay = delay - 1;
                    end
                end
            end
        end
    end

    initial begin
        int   idle;
        int   lastRetired;
        logic timedOut;
        arstN = 1'b1;
        #1;
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        idle = 0;
        lastRetired = 0;
        timedOut = 1'b0;
        while (retired < 600 && !timedOut) begin
            @(posedge clk);
            if (retired != lastRetired) begin
                lastRetired = retired;
                idle = 0;
            end else begin
                idle++;
                if (idle >= 200) begin
                    timedOut = 1'b1;
                end
            end
        end
        if (timedOut) begin
            $display("Timeout: nothing retired for 200 cycles after %0d retires", retired);
        end
        $display("Retired %0d, retire errors %0d, protocol errors %0d",
                 retired, retireErrors, protocolErrors);
        if (!timedOut && retireErrors == 0 && protocolErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+design
design/corePkg.sv
design/coreIfs.sv
design/fetchUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/regFile.sv
design/cpuCore.sv
testbench/retireChecker.sv
testbench/tbCpuCore.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module tbCpuCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/VtbCpuCore)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx 'ALL TESTS PASSED'; then
    exit 0
fi
exit 1
